/* rtl/mpuConfigPkg.sv */
// Sizing constants for the MPU retirement path
// Issue numbers double as commit table slots, so issueNoWidth
// must stay at log2 of numEntry
// Latency field is four bits, so the longest op runs 15 cycles
package mpuConfigPkg;

	////////////////////////////////////////////////////////////
	// Commit table
	////////////////////////////////////////////////////////////
	localparam int numEntry       = 8;                        // Table depth
	localparam int issueNoWidth   = 3;                        // One issue number per slot
	localparam int occupancyWidth = $clog2(numEntry + 1);     // Count 0..numEntry

	////////////////////////////////////////////////////////////
	// Execution lanes
	////////////////////////////////////////////////////////////
	localparam int numLanes       = 4;
	localparam int laneIndexWidth = 2;

	// Operation fields
	localparam int tagWidth       = 8;
	localparam int latencyWidth   = 4;                        // Zero is run as one

	localparam int stallCountWidth = 8;                       // Saturating stall counter

endpackage

/* rtl/mpuTypesPkg.sv */
// Shared types for the MPU retirement path
// Widths come from mpuConfigPkg, so both packages compile together
// and the config package goes first
package mpuTypesPkg;
	import mpuConfigPkg::*;

	////////////////////////////////////////////////////////////
	// Field types
	////////////////////////////////////////////////////////////

	// Issue number, also the commit table slot
	typedef logic [issueNoWidth-1:0]   issueNo_t;

	// Opaque tag carried from issue to commit
	typedef logic [tagWidth-1:0]       opTag_t;

	// Requested execution time in cycles
	typedef logic [latencyWidth-1:0]   latency_t;

	// Execution lane number
	typedef logic [laneIndexWidth-1:0] laneIndex_t;

	////////////////////////////////////////////////////////////
	// Lane FSM
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		laneIdle = 2'b00,     // Free for a new op
		laneBusy = 2'b01,     // Counting down
		laneDone = 2'b10      // Finished and waiting for the arbiter
	} laneState_t;

endpackage

/* rtl/ringBufferControl.sv */
// Pointer control for a circular table of numEntry slots
// Pointers wrap by width, so numEntry must be a power of two
// Caller must not write when full or read when empty
// Simultaneous write and read leave the occupancy unchanged
`timescale 1ns/100ps

module ringBufferControl
	import mpuConfigPkg::*;
	import mpuTypesPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     writeEnable,    // Allocate slot at writeAddr
	input  logic     readEnable,     // Release slot at readAddr
	output issueNo_t writeAddr,
	output issueNo_t readAddr,
	output logic     full,
	output logic     empty
);

	issueNo_t                  writePtr;
	issueNo_t                  readPtr;
	logic [occupancyWidth-1:0] occupancy;   // Live slots

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr  <= '0;
			readPtr   <= '0;
			occupancy <= '0;
		end else begin
			if (writeEnable) writePtr <= writePtr + issueNo_t'(1);   // Wraps at numEntry
			if (readEnable)  readPtr  <= readPtr + issueNo_t'(1);

			// Net change only when exactly one side moves
			if (writeEnable && !readEnable) begin
				occupancy <= occupancy + occupancyWidth'(1);
			end else if (readEnable && !writeEnable) begin
				occupancy <= occupancy - occupancyWidth'(1);
			end
		end
	end

	assign writeAddr = writePtr;
	assign readAddr  = readPtr;
	assign full      = (occupancy == occupancyWidth'(numEntry));
	assign empty     = (occupancy == '0);

	// Overflow or underflow means the user broke the handshake
	noWriteWhenFull: assert property (@(posedge clock) disable iff (reset)
		!(writeEnable && full))
		else $error("ringBufferControl write while full");

	noReadWhenEmpty: assert property (@(posedge clock) disable iff (reset)
		!(readEnable && empty))
		else $error("ringBufferControl read while empty");

endmodule

/* rtl/issueDispatch.sv */
// Accepts one op per cycle and sends it to a lane and the commit table
// Issue number is the commit table write slot passed in as slotNo
// All outputs besides opReady are single-cycle pulses on acceptance
// opReady stays low for one cycle after reset
// Source must hold opValid and its fields while stalled
`timescale 1ns/100ps

module issueDispatch
	import mpuConfigPkg::*;
	import mpuTypesPkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                opValid,
	input  opTag_t              opTag,
	input  latency_t            opLatency,
	output logic                opReady,
	input  logic                tableFull,
	input  issueNo_t            slotNo,
	input  logic [numLanes-1:0] laneIdle,
	output logic                issueReq,
	output issueNo_t            issueNo,
	output opTag_t              issueTag,
	output logic                startReq,
	output laneIndex_t          startLane,
	output issueNo_t            startIssueNo,
	output latency_t            startLatency
);

	laneIndex_t                 freeLane;        // Lowest idle lane
	logic                       anyIdle;
	logic                       dispatchArmed;   // Low for the first cycle out of reset
	logic                       accept;
	logic [stallCountWidth-1:0] stallCount;      // Cycles the current op has waited

	////////////////////////////////////////////////////////////
	// Lane pick
	////////////////////////////////////////////////////////////
	always_comb begin
		freeLane = '0;
		anyIdle  = 1'b0;
		for (int i = numLanes - 1; i >= 0; i--) begin   // Last hit is the lowest lane
			if (laneIdle[i]) begin
				freeLane = laneIndex_t'(i);
				anyIdle  = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) dispatchArmed <= 1'b0;
		else       dispatchArmed <= 1'b1;
	end

	assign opReady = dispatchArmed && !tableFull && anyIdle;
	assign accept  = opValid && opReady;

	// Fan out with no register stage
	assign issueReq     = accept;
	assign issueNo      = slotNo;
	assign issueTag     = opTag;
	assign startReq     = accept;
	assign startLane    = freeLane;
	assign startIssueNo = slotNo;
	assign startLatency = (opLatency == '0) ? latency_t'(1) : opLatency;   // Zero runs as one

	////////////////////////////////////////////////////////////
	// Stall tracking
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			stallCount <= '0;
		end else if (opValid && !opReady) begin
			if (stallCount != '1) stallCount <= stallCount + stallCountWidth'(1);   // Saturate
		end else begin
			stallCount <= '0;
		end
	end

	// Stalled op must be held by the source until taken
	stallHoldsOp: assert property (@(posedge clock) disable iff (reset)
		(stallCount != '0) |-> (opValid && $stable(opTag) && $stable(opLatency)))
		else $error("issueDispatch op changed while stalled");

endmodule

/* rtl/executionLanes.sv */
// Four execution lanes with one shared completion port
// A lane loaded at edge E reports done after startLatency cycles
// Fixed priority lets the lowest lane win while losers wait in laneDone
// startLatency must be nonzero as dispatch clamps zero to one
// startReq must target an idle lane
`timescale 1ns/100ps

module executionLanes
	import mpuConfigPkg::*;
	import mpuTypesPkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                startReq,
	input  laneIndex_t          startLane,
	input  issueNo_t            startIssueNo,
	input  latency_t            startLatency,
	output logic [numLanes-1:0] laneIdle,
	output logic                doneReq,
	output issueNo_t            doneIssueNo
);

	laneState_t          laneState   [numLanes];
	latency_t            laneCount   [numLanes];   // Cycles left while busy
	issueNo_t            laneIssueNo [numLanes];   // Op held by the lane
	logic [numLanes-1:0] loadLane;                 // One-hot start
	logic [numLanes-1:0] grantLane;                // One-hot release
	laneIndex_t          grantIndex;

	always_comb begin
		for (int i = 0; i < numLanes; i++) begin
			loadLane[i] = startReq && (startLane == laneIndex_t'(i));
			laneIdle[i] = (laneState[i] == mpuTypesPkg::laneIdle);
		end
	end

	////////////////////////////////////////////////////////////
	// Lane FSMs
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		for (int i = 0; i < numLanes; i++) begin
			if (reset) begin
				laneState[i] <= mpuTypesPkg::laneIdle;
			end else begin
				case (laneState[i])
					mpuTypesPkg::laneIdle: begin
						if (loadLane[i]) laneState[i] <= laneBusy;
					end
					laneBusy: begin
						if (laneCount[i] <= latency_t'(1)) laneState[i] <= laneDone;   // Last cycle
					end
					laneDone: begin
						if (grantLane[i]) laneState[i] <= mpuTypesPkg::laneIdle;   // Reported
					end
					default: laneState[i] <= mpuTypesPkg::laneIdle;
				endcase
			end
		end
	end

	// Payload is only meaningful while not idle
	always_ff @(posedge clock) begin
		for (int i = 0; i < numLanes; i++) begin
			if (loadLane[i]) begin
				laneCount[i]   <= startLatency;
				laneIssueNo[i] <= startIssueNo;
			end else if (laneState[i] == laneBusy) begin
				laneCount[i]   <= laneCount[i] - latency_t'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Completion arbiter
	////////////////////////////////////////////////////////////
	always_comb begin
		grantIndex = '0;
		doneReq    = 1'b0;
		for (int i = numLanes - 1; i >= 0; i--) begin   // Lowest done lane ends up granted
			if (laneState[i] == laneDone) begin
				grantIndex = laneIndex_t'(i);
				doneReq    = 1'b1;
			end
		end
		for (int i = 0; i < numLanes; i++) begin
			grantLane[i] = doneReq && (grantIndex == laneIndex_t'(i));
		end
	end

	assign doneIssueNo = laneIssueNo[grantIndex];

	// Dispatch picks from laneIdle, so a start on a busy lane is a wiring fault
	startOnIdleLane: assert property (@(posedge clock) disable iff (reset)
		startReq |-> laneIdle[startLane])
		else $error("executionLanes start on busy lane %0d", startLane);

endmodule

/* rtl/commitOrder.sv */
// In-order commit table for out-of-order completions
// Slot number equals issue number
// Issue must not arrive when the table is full
// Retires at most one op per cycle through a registered output
// Output has no back-pressure
`timescale 1ns/100ps

module commitOrder
	import mpuConfigPkg::*;
	import mpuTypesPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     issueReq,
	input  issueNo_t issueNo,
	input  opTag_t   issueTag,
	input  logic     doneReq,
	input  issueNo_t doneIssueNo,
	output issueNo_t slotNo,          // Next issue number
	output logic     tableFull,
	output logic     commitValid,
	output issueNo_t commitIssueNo,
	output opTag_t   commitTag
);

	logic [numEntry-1:0] entryValid;            // Slot holds an op in flight
	logic [numEntry-1:0] entryDone;             // Lane has reported it
	opTag_t              entryTag [numEntry];
	issueNo_t            headSlot;              // Oldest op
	logic                headEmpty;
	logic                retire;

	////////////////////////////////////////////////////////////
	// Slot pointers
	////////////////////////////////////////////////////////////
	ringBufferControl commitPtr (
		.clock       (clock),
		.reset       (reset),
		.writeEnable (issueReq),
		.readEnable  (retire),
		.writeAddr   (slotNo),
		.readAddr    (headSlot),
		.full        (tableFull),
		.empty       (headEmpty)
	);

	// Head leaves once its lane has finished
	assign retire = !headEmpty && entryValid[headSlot] && entryDone[headSlot];

	////////////////////////////////////////////////////////////
	// Entry flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			entryValid <= '0;
			entryDone  <= '0;
		end else begin
			if (doneReq) entryDone[doneIssueNo] <= 1'b1;
			if (retire)  entryValid[headSlot]   <= 1'b0;
			if (issueReq) begin                  // Never the head slot while the table has room
				entryValid[issueNo] <= 1'b1;
				entryDone[issueNo]  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issueReq) entryTag[issueNo] <= issueTag;
	end

	////////////////////////////////////////////////////////////
	// Commit output
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) commitValid <= 1'b0;
		else       commitValid <= retire;
	end

	always_ff @(posedge clock) begin
		if (retire) begin
			commitIssueNo <= headSlot;
			commitTag     <= entryTag[headSlot];
		end
	end

	// Lanes may only report ops that are still pending
	doneOnValidEntry: assert property (@(posedge clock) disable iff (reset)
		doneReq |-> entryValid[doneIssueNo])
		else $error("commitOrder completion for empty slot %0d", doneIssueNo);

	doneOnlyOnce: assert property (@(posedge clock) disable iff (reset)
		doneReq |-> !entryDone[doneIssueNo])
		else $error("commitOrder second completion for slot %0d", doneIssueNo);

endmodule

/* rtl/mpuCommitTop.sv */
// Retirement subsystem top with dispatch, lanes and commit table
// Op input uses valid/ready and commit output is a pulse without back-pressure
// Without contention commit follows acceptance by latency plus 2 cycles
`timescale 1ns/100ps

module mpuCommitTop
	import mpuConfigPkg::*;
	import mpuTypesPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     opValid,
	input  opTag_t   opTag,
	input  latency_t opLatency,
	output logic     opReady,
	output logic     commitValid,
	output issueNo_t commitIssueNo,
	output opTag_t   commitTag
);

	// Dispatch to table
	logic                issueReq;
	issueNo_t            issueNo;
	opTag_t              issueTag;
	issueNo_t            slotNo;
	logic                tableFull;

	// Dispatch to lanes
	logic                startReq;
	laneIndex_t          startLane;
	issueNo_t            startIssueNo;
	latency_t            startLatency;
	logic [numLanes-1:0] laneIdle;

	// Lanes to table
	logic                doneReq;
	issueNo_t            doneIssueNo;

	issueDispatch dispatch (
		.clock, .reset, .opValid, .opTag, .opLatency, .opReady,
		.tableFull, .slotNo, .laneIdle,
		.issueReq, .issueNo, .issueTag,
		.startReq, .startLane, .startIssueNo, .startLatency
	);

	executionLanes lanes (
		.clock, .reset,
		.startReq, .startLane, .startIssueNo, .startLatency,
		.laneIdle, .doneReq, .doneIssueNo
	);

	commitOrder commit (
		.clock, .reset,
		.issueReq, .issueNo, .issueTag,
		.doneReq, .doneIssueNo,
		.slotNo, .tableFull,
		.commitValid, .commitIssueNo, .commitTag
	);

endmodule

/* tb/commitChecker.sv */
// Scoreboard for mpuCommitTop that watches the top-level ports only
// Samples on the falling edge, where every DUT port is settled
// Expects issue numbers to be handed out as acceptance count mod numEntry
// Closing report runs once, on the first sample with drained high
`timescale 1ns/100ps

module commitChecker
	import mpuConfigPkg::*;
	import mpuTypesPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     opValid,
	input  opTag_t   opTag,
	input  logic     opReady,
	input  logic     commitValid,
	input  issueNo_t commitIssueNo,
	input  opTag_t   commitTag,
	input  logic     drained,        // Stimulus done and pipeline empty
	input  int       expectedOps,    // Ops the testbench sent
	output int       pendingCount,
	output int       errorCount,
	output logic     reportDone
);

	typedef logic [issueNoWidth+tagWidth-1:0] pair_t;   // {issue number, tag}

	pair_t pending [$];              // Accepted but not yet committed
	pair_t oldest;
	int    acceptCount  = 0;
	int    commitCount  = 0;
	int    checkCount   = 0;
	int    errors       = 0;
	int    inFlight     = 0;
	int    peakInFlight = 0;
	logic  resetPrev    = 1'b1;
	logic  finished     = 1'b0;

	assign pendingCount = inFlight;
	assign errorCount   = errors;
	assign reportDone   = finished;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Expected pair for the n-th accepted op
	function automatic pair_t expectedPair(input int acceptIndex, input opTag_t tag);
		issueNo_t slot;
		slot = issueNo_t'(acceptIndex % numEntry);   // Slots handed out round the ring
		return {slot, tag};
	endfunction

	task automatic flagMismatch(input string signalName, input logic [31:0] actual,
		input logic [31:0] wanted);
		errors++;
		$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
			signalName, actual, wanted, $time);
	endtask

	task automatic closeReport();
		checkCount += 4;
		if (pending.size() != 0) begin
			errors++;
			$display("Drain incomplete, %0d accepted operations never committed",
				pending.size());
		end
		if (acceptCount != expectedOps) begin
			errors++;
			$display("DUT accepted %0d operations but %0d were sent", acceptCount, expectedOps);
		end
		if (commitCount != acceptCount) begin
			errors++;
			$display("Committed %0d operations out of %0d accepted", commitCount, acceptCount);
		end
		if (peakInFlight < numEntry) begin   // Head-stall phase should fill the table
			errors++;
			$display("In-flight count peaked at %0d, commit table never filled", peakInFlight);
		end
		$display("Checker summary: %0d errors in %0d checks", errors, checkCount);
		finished = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Per-cycle comparison
	////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		if (!reset && resetPrev) begin          // First cycle out of reset
			checkCount += 2;
			if (opReady !== 1'b0)     flagMismatch("opReady", 32'(opReady), 32'h0);
			if (commitValid !== 1'b0) flagMismatch("commitValid", 32'(commitValid), 32'h0);
		end
		resetPrev = reset;

		if (!reset && !finished) begin
			// Commit first since its slot is already free this cycle
			if (commitValid) begin
				if (pending.size() == 0) begin
					errors++;
					$display("Commit of issue %0h with no operation pending", commitIssueNo);
				end else begin
					oldest = pending.pop_front();
					commitCount++;
					checkCount += 2;
					if (commitIssueNo !== oldest[tagWidth +: issueNoWidth])
						flagMismatch("commitIssueNo", 32'(commitIssueNo),
							32'(oldest[tagWidth +: issueNoWidth]));
					if (commitTag !== oldest[tagWidth-1:0])
						flagMismatch("commitTag", 32'(commitTag), 32'(oldest[tagWidth-1:0]));
				end
			end

			if (pending.size() == numEntry) begin   // Input must stall while the table is full
				checkCount++;
				if (opReady !== 1'b0) flagMismatch("opReady", 32'(opReady), 32'h0);
			end

			if (opValid && opReady) begin
				pending.push_back(expectedPair(acceptCount, opTag));
				acceptCount++;
				checkCount++;
				if (pending.size() > numEntry) begin
					errors++;
					$display("In-flight count %0d exceeds table depth at %0t",
						pending.size(), $time);
				end
			end

			inFlight = pending.size();
			if (inFlight > peakInFlight) peakInFlight = inFlight;
			if (drained) closeReport();
		end
	end

endmodule

/* tb/mpuCommitTb.sv */
// Testbench for the MPU retirement subsystem
// Phases run random latencies, head stall, back-to-back burst, then drain
// Inputs change only on the rising edge and commitChecker does the comparing
`timescale 1ns/100ps

module mpuCommitTb
	import mpuTypesPkg::*;
();

	localparam int clockPeriod    = 100;
	localparam int randomOps      = 40;
	localparam int stallOps       = 12;
	localparam int burstOps       = 24;
	localparam int totalOps       = randomOps + stallOps + burstOps;
	localparam int maxOpCycles    = 15 + 4;          // Longest latency plus pipeline slack
	localparam int marginCycles   = 200;
	localparam int watchdogCycles = totalOps * maxOpCycles + marginCycles;

	logic        clock;
	logic        reset;
	logic        opValid;
	opTag_t      opTag;
	latency_t    opLatency;
	logic        opReady;
	logic        commitValid;
	issueNo_t    commitIssueNo;
	opTag_t      commitTag;
	logic        drained;
	int          pendingCount;
	int          errorCount;
	logic        reportDone;
	int          seed = 32'h125d_223c;
	logic [31:0] randWord;

	mpuCommitTop uut (
		.clock, .reset, .opValid, .opTag, .opLatency, .opReady,
		.commitValid, .commitIssueNo, .commitTag
	);

	commitChecker commitCheck (
		.clock, .reset, .opValid, .opTag, .opReady,
		.commitValid, .commitIssueNo, .commitTag,
		.drained, .expectedOps (totalOps),
		.pendingCount, .errorCount, .reportDone
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Present one op and hold it until the DUT takes it
	task automatic sendOp(input opTag_t tag, input latency_t latency);
		logic readySeen;
		opValid   <= 1'b1;
		opTag     <= tag;
		opLatency <= latency;
		readySeen = 1'b0;
		while (!readySeen) begin
			@(negedge clock);
			readySeen = opReady;                  // Transfer on the coming edge
			@(posedge clock);
		end
	endtask

	// Idle the input until every accepted op has committed
	task automatic waitDrain();
		opValid <= 1'b0;
		@(posedge clock);
		while (pendingCount != 0) @(posedge clock);
		repeat (4) @(posedge clock);          // Catch stray commits
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		reset     = 1'b1;
		opValid   = 1'b0;
		opTag     = '0;
		opLatency = '0;
		drained   = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);                     // Checker looks at this cycle

		// Random latencies make completions land out of order
		for (int i = 0; i < randomOps; i++) begin
			randWord = $random(seed);
			sendOp(randWord[7:0], randWord[11:8]);
			if (randWord[12]) begin       // Occasional bubble
				opValid <= 1'b0;
				@(posedge clock);
			end
		end
		waitDrain();

		// Short ops pile up behind a long head op until the table fills
		randWord = $random(seed);
		sendOp(randWord[7:0], latency_t'(15));
		for (int i = 1; i < stallOps; i++) begin
			randWord = $random(seed);
			sendOp(randWord[7:0], latency_t'(1));
		end
		waitDrain();

		// Back-to-back burst behind a slow head with opValid held through stalls
		sendOp(opTag_t'(8'h7f), latency_t'(12));
		for (int i = 1; i < burstOps; i++) begin
			randWord = $random(seed);
			sendOp(opTag_t'(i + 8'h80), {2'b00, randWord[9:8]});   // Zero latency included
		end
		waitDrain();

		drained <= 1'b1;
		wait (reportDone);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog sized from the op count and worst-case latency
	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Watchdog expired after %0d cycles, run did not finish", watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* mpuCommitTop.f */
rtl/mpuConfigPkg.sv
rtl/mpuTypesPkg.sv
rtl/ringBufferControl.sv
rtl/issueDispatch.sv
rtl/executionLanes.sv
rtl/commitOrder.sv
rtl/mpuCommitTop.sv
tb/commitChecker.sv
tb/mpuCommitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the retirement subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mpuCommitTb \
	-f mpuCommitTop.f --Mdir obj_dir -o mpuCommitSim \
	|| { echo "Verilator build failed"; exit 1; }

simOutput="$(./obj_dir/mpuCommitSim 2>&1)"
echo "$simOutput"

grep -q "ALL CHECKS PASSED" <<< "$simOutput" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
